// File: hw/cache_cfg_pkg.sv
// cache geometry and address-field types, referenced by scoped name from the RTL and testbench
package cache_cfg_pkg;

    // port widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;

    // organisation
    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 16;
    localparam int LINE_BYTES     = 128;
    localparam int BEATS_PER_LINE = LINE_BYTES / STRB_W;

    // address split: tag | index | beat | byte
    localparam int OFFSET_W = $clog2(LINE_BYTES);
    localparam int INDEX_W  = $clog2(NUM_SETS);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WAY_W    = $clog2(NUM_WAYS);
    localparam int BEAT_W   = $clog2(BEATS_PER_LINE);

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [DATA_W-1:0] data_t;

    typedef logic [STRB_W-1:0] strb_t;

    typedef logic [TAG_W-1:0] tag_t;

    typedef logic [INDEX_W-1:0] index_t;

    typedef logic [WAY_W-1:0] way_t;

    // word position inside a line, also the burst beat number
    typedef logic [BEAT_W-1:0] beat_t;

endpackage

// File: hw/cache_bus_pkg.sv
// port structs for the CPU and memory sides of the cache, plus the controller state encoding
package cache_bus_pkg;

    // cpu request, a nonzero strb makes it a write
    typedef struct packed {
        cache_cfg_pkg::addr_t addr;
        cache_cfg_pkg::data_t wdata;
        cache_cfg_pkg::strb_t strb;
    } cpu_req_t;

    typedef struct packed {
        cache_cfg_pkg::data_t rdata;
    } cpu_rsp_t;

    // line-aligned start of a 16-beat burst, shared by ar and aw
    typedef struct packed {
        cache_cfg_pkg::addr_t addr;
    } mem_addr_t;

    typedef struct packed {
        cache_cfg_pkg::data_t data;
        logic                 last;
    } mem_rbeat_t;

    // write beats are always full words
    typedef struct packed {
        cache_cfg_pkg::data_t data;
        logic                 last;
    } mem_wbeat_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WRITEBACK,
        REFILL_REQ,
        REFILL
    } ctrl_state_t;

endpackage

// File: hw/cache_tag_store.sv
// tag, valid and dirty arrays with hit detection and per-set round-robin victim choice
`timescale 1ns/1ps

module cache_tag_store (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_cfg_pkg::index_t index,
    input  cache_cfg_pkg::tag_t   tag,
    input  logic                  fill,
    input  logic                  mark_dirty,
    input  logic                  advance_victim,
    output logic                  hit,
    output cache_cfg_pkg::way_t   hit_way,
    output cache_cfg_pkg::way_t   victim_way,
    output logic                  victim_dirty,
    output cache_cfg_pkg::tag_t   victim_tag
);

    logic [cache_cfg_pkg::NUM_SETS-1:0][cache_cfg_pkg::NUM_WAYS-1:0] valid_q;
    logic [cache_cfg_pkg::NUM_SETS-1:0][cache_cfg_pkg::NUM_WAYS-1:0] dirty_q;

    cache_cfg_pkg::tag_t tag_q [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];

    // replacement pointer per set
    cache_cfg_pkg::way_t [cache_cfg_pkg::NUM_SETS-1:0] rr_q;

    logic [cache_cfg_pkg::NUM_WAYS-1:0] hit_vec;
    cache_cfg_pkg::way_t                fill_way;

    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[index][w] && (tag_q[index][w] == tag);
            if (hit_vec[w]) begin
                hit_way = cache_cfg_pkg::way_t'(w);
            end
        end
    end

    assign hit = |hit_vec;

    assign victim_way   = rr_q[index];
    assign victim_dirty = valid_q[index][victim_way] && dirty_q[index][victim_way];
    assign victim_tag   = tag_q[index][victim_way];

    // pointer already stepped at the miss, so the victim sits one behind it
    assign fill_way = rr_q[index] - cache_cfg_pkg::way_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            rr_q    <= '0;
        end else begin
            if (fill) begin
                valid_q[index][fill_way] <= 1'b1;
                dirty_q[index][fill_way] <= 1'b0;
            end
            if (mark_dirty) begin
                dirty_q[index][hit_way] <= 1'b1;
            end
            if (advance_victim) begin
                rr_q[index] <= rr_q[index] + cache_cfg_pkg::way_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[index][fill_way] <= tag;
        end
    end

    // a refill never installs a tag already present in the set
    a_single_hit: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(hit_vec)
    );

endmodule

// File: hw/cache_data_store.sv
// behavioural line storage, byte-masked word writes and combinational word reads
`timescale 1ns/1ps

module cache_data_store (
    input  logic                  clk,
    input  cache_cfg_pkg::index_t set,
    input  cache_cfg_pkg::way_t   way,
    input  cache_cfg_pkg::beat_t  beat,
    input  logic                  wen,
    input  cache_cfg_pkg::strb_t  wmask,
    input  cache_cfg_pkg::data_t  wdata,
    output cache_cfg_pkg::data_t  rdata
);

    // sets x ways x words
    cache_cfg_pkg::data_t mem_q [cache_cfg_pkg::NUM_SETS]
                                [cache_cfg_pkg::NUM_WAYS]
                                [cache_cfg_pkg::BEATS_PER_LINE];

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < cache_cfg_pkg::STRB_W; b++) begin
                if (wmask[b]) begin
                    mem_q[set][way][beat][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // read sees the word as it stands before this cycle's write
    assign rdata = mem_q[set][way][beat];

endmodule

// File: hw/cache_ctrl.sv
// request FSM for the cache: lookup, write-back and refill bursts, and the CPU response
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  cache_bus_pkg::cpu_req_t req,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output cache_bus_pkg::cpu_rsp_t rsp,
    output logic                    ar_valid,
    input  logic                    ar_ready,
    output cache_bus_pkg::mem_addr_t ar,
    input  logic                    r_valid,
    input  cache_bus_pkg::mem_rbeat_t r,
    output logic                    aw_valid,
    input  logic                    aw_ready,
    output cache_bus_pkg::mem_addr_t aw,
    output logic                    w_valid,
    input  logic                    w_ready,
    output cache_bus_pkg::mem_wbeat_t w,
    input  logic                    hit,
    input  cache_cfg_pkg::way_t     hit_way,
    input  cache_cfg_pkg::way_t     victim_way,
    input  logic                    victim_dirty,
    input  cache_cfg_pkg::tag_t     victim_tag,
    input  cache_cfg_pkg::data_t    line_rdata,
    output cache_cfg_pkg::index_t   lk_index,
    output cache_cfg_pkg::tag_t     lk_tag,
    output logic                    fill,
    output logic                    mark_dirty,
    output logic                    advance_victim,
    output cache_cfg_pkg::way_t     ds_way,
    output cache_cfg_pkg::beat_t    ds_beat,
    output logic                    ds_wen,
    output cache_cfg_pkg::strb_t    ds_wmask,
    output cache_cfg_pkg::data_t    ds_wdata
);

    cache_bus_pkg::ctrl_state_t state_q;
    cache_bus_pkg::ctrl_state_t state_d;

    cache_bus_pkg::cpu_req_t req_q;
    cache_bus_pkg::cpu_rsp_t rsp_q;
    cache_cfg_pkg::way_t     vic_way_q;
    cache_cfg_pkg::tag_t     vic_tag_q;
    cache_cfg_pkg::beat_t    wb_beat_q;
    cache_cfg_pkg::beat_t    rf_beat_q;
    cache_cfg_pkg::beat_t    lk_beat;
    logic                    aw_done_q;
    logic                    req_write;

    assign lk_tag    = req_q.addr[cache_cfg_pkg::ADDR_W-1 -: cache_cfg_pkg::TAG_W];
    assign lk_index  = req_q.addr[cache_cfg_pkg::OFFSET_W +: cache_cfg_pkg::INDEX_W];
    assign lk_beat   = req_q.addr[cache_cfg_pkg::OFFSET_W-1 -: cache_cfg_pkg::BEAT_W];
    assign req_write = |req_q.strb;

    assign req_ready = (state_q == cache_bus_pkg::IDLE);
    assign rsp_valid = (state_q == cache_bus_pkg::RESPOND);
    assign rsp       = rsp_q;

    assign ar_valid = (state_q == cache_bus_pkg::REFILL_REQ);
    assign ar.addr  = {lk_tag, lk_index, {cache_cfg_pkg::OFFSET_W{1'b0}}};

    // address phase first, then the 16 data beats
    assign aw_valid = (state_q == cache_bus_pkg::WRITEBACK) && !aw_done_q;
    assign aw.addr  = {vic_tag_q, lk_index, {cache_cfg_pkg::OFFSET_W{1'b0}}};
    assign w_valid  = (state_q == cache_bus_pkg::WRITEBACK) && aw_done_q;
    assign w.data   = line_rdata;
    assign w.last   = &wb_beat_q;

    always_comb begin
        state_d        = state_q;
        fill           = 1'b0;
        mark_dirty     = 1'b0;
        advance_victim = 1'b0;
        ds_way         = vic_way_q;
        ds_beat        = lk_beat;
        ds_wen         = 1'b0;
        ds_wmask       = '0;
        ds_wdata       = req_q.wdata;
        case (state_q)
            cache_bus_pkg::IDLE: begin
                if (req_valid) begin
                    state_d = cache_bus_pkg::LOOKUP;
                end
            end
            cache_bus_pkg::LOOKUP: begin
                ds_way = hit_way;
                if (hit) begin
                    ds_wen     = req_write;
                    ds_wmask   = req_q.strb;
                    mark_dirty = req_write;
                    state_d    = cache_bus_pkg::RESPOND;
                end else begin
                    advance_victim = 1'b1;
                    state_d = victim_dirty ? cache_bus_pkg::WRITEBACK : cache_bus_pkg::REFILL_REQ;
                end
            end
            cache_bus_pkg::RESPOND: begin
                if (rsp_ready) begin
                    state_d = cache_bus_pkg::IDLE;
                end
            end
            cache_bus_pkg::WRITEBACK: begin
                ds_beat = wb_beat_q;
                if (w_valid && w_ready && w.last) begin
                    state_d = cache_bus_pkg::REFILL_REQ;
                end
            end
            cache_bus_pkg::REFILL_REQ: begin
                if (ar_ready) begin
                    state_d = cache_bus_pkg::REFILL;
                end
            end
            cache_bus_pkg::REFILL: begin
                ds_beat  = rf_beat_q;
                ds_wen   = r_valid;
                ds_wmask = '1;
                ds_wdata = r.data;
                // line complete, go back and look it up again
                if (r_valid && r.last) begin
                    fill    = 1'b1;
                    state_d = cache_bus_pkg::LOOKUP;
                end
            end
            default: begin
                state_d = cache_bus_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= cache_bus_pkg::IDLE;
            aw_done_q <= 1'b0;
            wb_beat_q <= '0;
            rf_beat_q <= '0;
        end else begin
            state_q <= state_d;
            if (aw_valid && aw_ready) begin
                aw_done_q <= 1'b1;
            end else if (w_valid && w_ready && w.last) begin
                aw_done_q <= 1'b0;
            end
            // counters wrap to zero after beat 15
            if (w_valid && w_ready) begin
                wb_beat_q <= wb_beat_q + 1'b1;
            end
            if ((state_q == cache_bus_pkg::REFILL) && r_valid) begin
                rf_beat_q <= rf_beat_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= '0;
        end else if (req_valid && req_ready) begin
            req_q <= req;
        end
        if ((state_q == cache_bus_pkg::LOOKUP) && hit) begin
            rsp_q.rdata <= line_rdata;
        end
        if ((state_q == cache_bus_pkg::LOOKUP) && !hit) begin
            vic_way_q <= victim_way;
            vic_tag_q <= victim_tag;
        end
    end

    a_ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar)
    );

    a_aw_hold: assert property (
        @(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw)
    );

    // memory must flag last on the 16th refill beat and nowhere else
    a_r_last: assert property (
        @(posedge clk) disable iff (rst)
        (state_q == cache_bus_pkg::REFILL) && r_valid |-> (r.last == (&rf_beat_q))
    );

endmodule

// File: hw/cache_top.sv
// cache top level, controller plus tag and data stores behind a CPU port and a burst memory port
`timescale 1ns/1ps

module cache_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  cache_bus_pkg::cpu_req_t   req,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output cache_bus_pkg::cpu_rsp_t   rsp,
    output logic                      ar_valid,
    input  logic                      ar_ready,
    output cache_bus_pkg::mem_addr_t  ar,
    input  logic                      r_valid,
    input  cache_bus_pkg::mem_rbeat_t r,
    output logic                      aw_valid,
    input  logic                      aw_ready,
    output cache_bus_pkg::mem_addr_t  aw,
    output logic                      w_valid,
    input  logic                      w_ready,
    output cache_bus_pkg::mem_wbeat_t w
);

    // lookup path
    cache_cfg_pkg::index_t lk_index;
    cache_cfg_pkg::tag_t   lk_tag;
    logic                  hit;
    cache_cfg_pkg::way_t   hit_way;
    cache_cfg_pkg::way_t   victim_way;
    logic                  victim_dirty;
    cache_cfg_pkg::tag_t   victim_tag;
    logic                  fill;
    logic                  mark_dirty;
    logic                  advance_victim;

    // data store access
    cache_cfg_pkg::way_t   ds_way;
    cache_cfg_pkg::beat_t  ds_beat;
    logic                  ds_wen;
    cache_cfg_pkg::strb_t  ds_wmask;
    cache_cfg_pkg::data_t  ds_wdata;
    cache_cfg_pkg::data_t  line_rdata;

    cache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (rsp_ready),
        .rsp            (rsp),
        .ar_valid       (ar_valid),
        .ar_ready       (ar_ready),
        .ar             (ar),
        .r_valid        (r_valid),
        .r              (r),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .aw             (aw),
        .w_valid        (w_valid),
        .w_ready        (w_ready),
        .w              (w),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .victim_dirty   (victim_dirty),
        .victim_tag     (victim_tag),
        .line_rdata     (line_rdata),
        .lk_index       (lk_index),
        .lk_tag         (lk_tag),
        .fill           (fill),
        .mark_dirty     (mark_dirty),
        .advance_victim (advance_victim),
        .ds_way         (ds_way),
        .ds_beat        (ds_beat),
        .ds_wen         (ds_wen),
        .ds_wmask       (ds_wmask),
        .ds_wdata       (ds_wdata)
    );

    cache_tag_store u_tags (
        .clk            (clk),
        .rst            (rst),
        .index          (lk_index),
        .tag            (lk_tag),
        .fill           (fill),
        .mark_dirty     (mark_dirty),
        .advance_victim (advance_victim),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .victim_dirty   (victim_dirty),
        .victim_tag     (victim_tag)
    );

    // set always follows the registered request index
    cache_data_store u_data (
        .clk   (clk),
        .set   (lk_index),
        .way   (ds_way),
        .beat  (ds_beat),
        .wen   (ds_wen),
        .wmask (ds_wmask),
        .wdata (ds_wdata),
        .rdata (line_rdata)
    );

endmodule

// File: verification/burst_mem_model.sv
// burst memory for the cache testbench, answers ar/aw/w bursts with random ready stalls
`timescale 1ns/1ps

module burst_mem_model (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    input  cache_bus_pkg::mem_addr_t  ar,
    output logic                      r_valid,
    output cache_bus_pkg::mem_rbeat_t r,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  cache_bus_pkg::mem_addr_t  aw,
    input  logic                      w_valid,
    output logic                      w_ready,
    input  cache_bus_pkg::mem_wbeat_t w,
    output int                        wr_bursts,
    output cache_cfg_pkg::addr_t      last_wr_addr,
    output int                        errors
);

    localparam logic [63:0] INIT_XOR = 64'h5a5a_0000_0000_0000;
    localparam int          WORDS    = 4096;

    cache_cfg_pkg::data_t mem [WORDS];
    cache_cfg_pkg::addr_t rd_base;
    cache_cfg_pkg::addr_t wr_base;
    logic                 rd_active;
    int                   rd_beat;
    int                   wr_beat;
    logic [15:0]          lfsr;

    // galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic take_bit();
        take_bit = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endfunction

    // word index is the full word address for the range the tests use
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = 64'(i) ^ INIT_XOR;
        end
        lfsr = 16'd41;
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        r_valid = 1'b0;
        r = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            rd_active = 1'b0;
            rd_beat = 0;
            wr_beat = 0;
            wr_bursts = 0;
            last_wr_addr = '0;
            errors = 0;
        end else begin
            if (ar_valid && ar_ready) begin
                rd_base = ar.addr;
                rd_active = 1'b1;
                rd_beat = 0;
                if (ar.addr >= WORDS * 8) begin
                    errors++;
                    $display("memory model: read burst outside modelled range at %h", ar.addr);
                end
            end else if (r_valid) begin
                if (r.last) begin
                    rd_active = 1'b0;
                end
                rd_beat++;
            end
            if (aw_valid && aw_ready) begin
                wr_base = aw.addr;
                wr_beat = 0;
            end
            if (w_valid && w_ready) begin
                mem[(wr_base >> 3) + wr_beat] = w.data;
                if (w.last != (wr_beat == 15)) begin
                    errors++;
                    $display("memory model: last flag wrong on write beat %0d", wr_beat);
                end
                if (w.last) begin
                    wr_bursts++;
                    last_wr_addr = wr_base;
                end
                wr_beat++;
            end
        end
    end

    // readies and read beats change on the falling edge
    always @(negedge clk) begin
        ar_ready = take_bit();
        aw_ready = take_bit();
        w_ready = take_bit();
        r_valid = rd_active;
        r.data = mem[(rd_base >> 3) + rd_beat];
        r.last = (rd_beat == 15);
    end

endmodule

// File: verification/cache_tb.sv
// testbench top for the cache, replays the stimulus file and checks every response
`timescale 1ns/1ps

module cache_tb;

    localparam int MAX_TESTS       = 64;
    localparam int CYCLES_PER_TEST = 200;

    logic                      clk;
    logic                      rst;
    logic                      req_valid;
    logic                      req_ready;
    cache_bus_pkg::cpu_req_t   req;
    logic                      rsp_valid;
    logic                      rsp_ready;
    cache_bus_pkg::cpu_rsp_t   rsp;
    logic                      ar_valid;
    logic                      ar_ready;
    cache_bus_pkg::mem_addr_t  ar;
    logic                      r_valid;
    cache_bus_pkg::mem_rbeat_t r;
    logic                      aw_valid;
    logic                      aw_ready;
    cache_bus_pkg::mem_addr_t  aw;
    logic                      w_valid;
    logic                      w_ready;
    cache_bus_pkg::mem_wbeat_t w;

    // memory model bookkeeping
    int                        mem_wr_bursts;
    cache_cfg_pkg::addr_t      mem_last_wr_addr;
    int                        mem_errors;

    string                names [MAX_TESTS];
    logic                 wr_flag [MAX_TESTS];
    cache_cfg_pkg::addr_t addrs [MAX_TESTS];
    cache_cfg_pkg::data_t wdatas [MAX_TESTS];
    cache_cfg_pkg::strb_t strbs [MAX_TESTS];
    cache_cfg_pkg::data_t expects [MAX_TESTS];
    int                   holds [MAX_TESTS];
    int                   num_tests;
    int                   errors;
    int                   passed;
    int                   failed;
    int                   cycles;
    int                   limit;

    cache_top uut (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
        .r_valid(r_valid), .r(r),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
        .w_valid(w_valid), .w_ready(w_ready), .w(w)
    );

    burst_mem_model u_mem (
        .clk(clk), .rst(rst),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
        .r_valid(r_valid), .r(r),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
        .w_valid(w_valid), .w_ready(w_ready), .w(w),
        .wr_bursts(mem_wr_bursts), .last_wr_addr(mem_last_wr_addr), .errors(mem_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic load_stimulus();
        int                   fd;
        int                   n;
        string                line;
        string                nm;
        logic                 wf;
        cache_cfg_pkg::addr_t a;
        cache_cfg_pkg::data_t wd;
        cache_cfg_pkg::strb_t st;
        cache_cfg_pkg::data_t ex;
        int                   hd;
        fd = $fopen("verification/cache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                // comment lines start with a hash
                if (line.len() > 0 && line[0] != 8'h23) begin
                    n = $sscanf(line, "%s %h %h %h %h %h %d", nm, wf, a, wd, st, ex, hd);
                    if (n == 7) begin
                        names[num_tests] = nm;
                        wr_flag[num_tests] = wf;
                        addrs[num_tests] = a;
                        wdatas[num_tests] = wd;
                        strbs[num_tests] = st;
                        expects[num_tests] = ex;
                        holds[num_tests] = hd;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int i);
        string                   name;
        int                      lat;
        int                      errs_before;
        int                      mem_errs_before;
        int                      bursts_before;
        cache_bus_pkg::cpu_rsp_t held;
        name = names[i];
        errs_before = errors;
        mem_errs_before = mem_errors;
        bursts_before = mem_wr_bursts;
        req.addr = addrs[i];
        req.wdata = wdatas[i];
        req.strb = wr_flag[i] ? strbs[i] : '0;
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk);
        // accepting edge lies between these two falling edges
        @(negedge clk);
        req_valid = 1'b0;
        lat = 1;
        while (!rsp_valid) begin
            @(negedge clk);
            lat++;
        end
        held = rsp;
        if (!wr_flag[i]) begin
            assert (rsp.rdata == expects[i]) else begin
                $display("FAIL %s: expected %h, actual %h", name, expects[i], rsp.rdata);
                errors++;
            end
        end
        if (name.substr(0, 2) == "hit") begin
            assert (lat == 2) else begin
                $display("FAIL %s: expected latency 2, actual %0d", name, lat);
                errors++;
            end
        end
        repeat (holds[i]) begin
            @(negedge clk);
            assert (rsp_valid && rsp == held && !req_ready) else begin
                $display("%s: response changed or request port opened while held", name);
                errors++;
            end
        end
        // for reads a nonzero wdata names the line expected to be written back
        if (!wr_flag[i] && wdatas[i] != '0) begin
            assert (mem_wr_bursts == bursts_before + 1) else begin
                $display("%s: no write-back burst reached memory", name);
                errors++;
            end
            assert (mem_last_wr_addr == wdatas[i][31:0]) else begin
                $display("FAIL %s: expected %h, actual %h", name, wdatas[i][31:0],
                         mem_last_wr_addr);
                errors++;
            end
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
        errors += mem_errors - mem_errs_before;
        if (errors == errs_before) begin
            passed++;
            $display("%-12s passed", name);
        end else begin
            failed++;
            $display("%-12s failed", name);
        end
    endtask

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b0;
        num_tests = 0;
        errors = 0;
        passed = 0;
        failed = 0;
        cycles = 0;
        limit = 0;
        load_stimulus();
        limit = (num_tests + 1) * CYCLES_PER_TEST;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (req_ready && !rsp_valid && !ar_valid && !aw_valid && !w_valid) else begin
            $display("reset state wrong: ready or valid outputs not at their idle values");
            errors++;
        end
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 num_tests, passed, failed, errors);
        if (errors == 0 && num_tests > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verification/cache_stimulus.txt
# name wr addr wdata strb expected_rdata rsp_hold_cycles (hex except the hold count)
# reads with nonzero wdata expect a write-back burst to that line address
rd_miss0   0 00001088 0000000000000000 00 5a5a000000000211 0
hit_rd0    0 000010f8 0000000000000000 00 5a5a00000000021f 0
hit_wr0    1 00001088 1122334455667788 0f 0000000000000000 0
hit_rd1    0 00001088 0000000000000000 00 5a5a000055667788 5
rd_t4      0 00002080 0000000000000000 00 5a5a000000000410 0
rd_t6      0 00003090 0000000000000000 00 5a5a000000000612 1
rd_t8      0 000040a0 0000000000000000 00 5a5a000000000814 0
evict_t10  0 00005080 0000000000001080 00 5a5a000000000a10 0
rd_back    0 00001088 0000000000000000 00 5a5a000055667788 0
hit_rd2    0 000010f8 0000000000000000 00 5a5a00000000021f 0
wr_m0      1 00000200 cafef00ddeadbeef ff 0000000000000000 0
hit_rd3    0 00000200 0000000000000000 00 cafef00ddeadbeef 2
wr_m1      1 00000208 aabbccdd00000000 f0 0000000000000000 0
rd_m1      0 00000208 0000000000000000 00 aabbccdd00000041 3
rd_s4a     0 00000a08 0000000000000000 00 5a5a000000000141 0
wr_s4b     1 00001210 00000000000000ff 01 0000000000000000 0
rd_s4c     0 00001a18 0000000000000000 00 5a5a000000000343 0
evict_s4d  0 00002220 0000000000000200 00 5a5a000000000444 0
rd_s4e     0 00000208 0000000000000000 00 aabbccdd00000041 0
hit_s4f    0 00000200 0000000000000000 00 cafef00ddeadbeef 0
hit_s4g    0 00001210 0000000000000000 00 5a5a0000000002ff 0
evict_s4h  0 00002a00 0000000000001200 00 5a5a000000000540 4
rd_back2   0 00001210 0000000000000000 00 5a5a0000000002ff 0
hit_rd4    0 00001218 0000000000000000 00 5a5a000000000243 0

// File: vlog.f
hw/cache_cfg_pkg.sv
hw/cache_bus_pkg.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
verification/burst_mem_model.sv
verification/cache_tb.sv

// File: Bender.yml
package:
  name: cache

sources:
  - hw/cache_cfg_pkg.sv
  - hw/cache_bus_pkg.sv
  - hw/cache_tag_store.sv
  - hw/cache_data_store.sv
  - hw/cache_ctrl.sv
  - hw/cache_top.sv
  - target: test
    files:
      - verification/burst_mem_model.sv
      - verification/cache_tb.sv
